// File: design/branchPkg.sv
/*
 * Types and constants shared by the fetch front end.
 * Assumes fixed 4-byte instructions and a 32-bit address space.
 */
`default_nettype none

package branchPkg;

    // Instruction address
    typedef logic [31:0] pc_t;

    // 2-bit saturating counter, states at or above weakTaken predict taken
    typedef enum logic [1:0] {
        strongNotTaken = 2'b00,
        weakNotTaken   = 2'b01,
        weakTaken      = 2'b10,
        strongTaken    = 2'b11
    } satCounter_e;

    // Byte distance between sequential instructions
    localparam pc_t PcStep = 32'd4;

    // PC bits below the BTB index, always zero for aligned fetch
    localparam int InstrOffsetBits = 2;

endpackage

`default_nettype wire

// File: design/predictorUpdateIf.sv
/*
 * Training strobes from branch resolution to the BTB and the predictor.
 * All strobes are single-cycle and sampled on the rising clock edge.
 */
`default_nettype none

interface predictorUpdateIf #(
    parameter int HistoryBits = 5
);
    import branchPkg::*;

    logic                   btbWrite;
    pc_t                    btbPc;
    pc_t                    btbTarget;
    logic                   btbIsJump;
    logic                   phtWrite;
    logic [HistoryBits-1:0] phtIndex;
    logic                   phtTaken;
    logic                   ghrShift;
    logic                   ghrTaken;
    logic                   ghrClear;

    modport resolver (
        output btbWrite, btbPc, btbTarget, btbIsJump,
        output phtWrite, phtIndex, phtTaken,
        output ghrShift, ghrTaken, ghrClear
    );

    modport btb (input btbWrite, btbPc, btbTarget, btbIsJump);

    modport pht (input phtWrite, phtIndex, phtTaken, ghrShift, ghrTaken, ghrClear);

endinterface

`default_nettype wire

// File: design/fetchPc.sv
/*
 * Fetch PC register. A redirect wins over stall, so a mispredict
 * resolved during a stall still steers fetch on the next edge.
 */
`default_nettype none

module fetchPc #(
    parameter branchPkg::pc_t ResetPc = '0
) (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           stall_i,
    input  wire logic           redirect_i,
    input  wire branchPkg::pc_t redirectPc_i,
    input  wire logic           predTaken_i,
    input  wire branchPkg::pc_t predTarget_i,
    output branchPkg::pc_t      pc_o
);
    import branchPkg::*;

    pc_t pcNext;

    // Next-PC priority: redirect, stall, predicted target, sequential
    always_comb begin
        if (redirect_i) begin
            pcNext = redirectPc_i;
        end else if (stall_i) begin
            pcNext = pc_o;
        end else if (predTaken_i) begin
            pcNext = predTarget_i;
        end else begin
            pcNext = pc_o + PcStep;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o <= ResetPc;
        end else begin
            pc_o <= pcNext;
        end
    end

endmodule

`default_nettype wire

// File: design/targetBuffer.sv
/*
 * Direct-mapped BTB with full tags, so aliasing PCs never hit.
 * BtbEntries must be a power of two. A write shows on lookups next cycle.
 */
`default_nettype none

module targetBuffer #(
    parameter int BtbEntries = 16
) (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire branchPkg::pc_t lookupPc_i,
    predictorUpdateIf.btb       update,
    output logic                hit_o,
    output logic                isJump_o,
    output branchPkg::pc_t      target_o
);
    import branchPkg::*;

    localparam int IndexBits = $clog2(BtbEntries);
    localparam int TagBits   = 32 - IndexBits - InstrOffsetBits;

    typedef logic [IndexBits-1:0] btbIndex_t;
    typedef logic [TagBits-1:0]   btbTag_t;

    logic    entryValid  [BtbEntries];
    btbTag_t entryTag    [BtbEntries];
    logic    entryIsJump [BtbEntries];
    pc_t     entryTarget [BtbEntries];

    btbIndex_t lookupIndex;
    btbTag_t   lookupTag;
    btbIndex_t writeIndex;
    btbTag_t   writeTag;

    assign lookupIndex = lookupPc_i[InstrOffsetBits +: IndexBits];
    assign lookupTag   = lookupPc_i[31 -: TagBits];
    assign writeIndex  = update.btbPc[InstrOffsetBits +: IndexBits];
    assign writeTag    = update.btbPc[31 -: TagBits];

    // Lookup path
    assign hit_o    = entryValid[lookupIndex] && (entryTag[lookupIndex] == lookupTag);
    assign isJump_o = entryIsJump[lookupIndex];
    assign target_o = entryTarget[lookupIndex];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BtbEntries; i++) begin
                entryValid[i] <= 1'b0;
            end
        end else if (update.btbWrite) begin
            entryValid[writeIndex] <= 1'b1;
        end
    end

    // Entry payload, qualified by the valid bit above
    always_ff @(posedge clk) begin
        if (update.btbWrite) begin
            entryTag[writeIndex]    <= writeTag;
            entryIsJump[writeIndex] <= update.btbIsJump;
            entryTarget[writeIndex] <= update.btbTarget;
        end
    end

endmodule

`default_nettype wire

// File: design/historyPredictor.sv
/*
 * Global-history predictor, the GHR alone indexes the counter table.
 * The GHR is updated at resolution. HistoryBits must be at least 2.
 */
`default_nettype none

module historyPredictor #(
    parameter int HistoryBits = 5
) (
    input  wire logic             clk,
    input  wire logic             reset,
    predictorUpdateIf.pht         update,
    output logic                  predictTaken_o,
    output logic [HistoryBits-1:0] history_o
);
    import branchPkg::*;

    localparam int TableSize = 1 << HistoryBits;

    logic [HistoryBits-1:0] ghr;
    satCounter_e            counters [TableSize];
    satCounter_e            readCounter;

    // One step toward the outcome, saturating at either end
    function automatic satCounter_e stepCounter(satCounter_e cnt, logic taken);
        satCounter_e result;
        case (cnt)
            strongNotTaken: result = taken ? weakNotTaken : strongNotTaken;
            weakNotTaken:   result = taken ? weakTaken    : strongNotTaken;
            weakTaken:      result = taken ? strongTaken  : weakNotTaken;
            default:        result = taken ? strongTaken  : weakTaken;
        endcase
        return result;
    endfunction

    assign readCounter    = counters[ghr];
    assign predictTaken_o = (readCounter >= weakTaken);
    assign history_o      = ghr;

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
        end else if (update.ghrClear) begin
            ghr <= '0;
        end else if (update.ghrShift) begin
            ghr <= {ghr[HistoryBits-2:0], update.ghrTaken};
        end
    end

    // Counters restart weakly not-taken
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TableSize; i++) begin
                counters[i] <= weakNotTaken;
            end
        end else if (update.phtWrite) begin
            counters[update.phtIndex] <= stepCounter(counters[update.phtIndex],
                                                     update.phtTaken);
        end
    end

endmodule

`default_nettype wire

// File: design/branchResolve.sv
/*
 * Resolution logic, purely combinational. The caller supplies the
 * prediction and history snapshot taken when the instruction was fetched.
 */
`default_nettype none

module branchResolve #(
    parameter int HistoryBits = 5
) (
    input  wire logic                   resolveValid_i,
    input  wire branchPkg::pc_t         resolvePc_i,
    input  wire branchPkg::pc_t         resolveTarget_i,
    input  wire logic                   resolveIsJump_i,
    input  wire logic                   resolveTaken_i,
    input  wire logic                   resolvePredTaken_i,
    input  wire logic [HistoryBits-1:0] resolveHistory_i,
    output logic                        mispredict_o,
    output branchPkg::pc_t              redirectPc_o,
    predictorUpdateIf.resolver          update
);
    import branchPkg::*;

    logic actualTaken;
    logic condBranch;

    // Jumps are always taken
    assign actualTaken = resolveIsJump_i || resolveTaken_i;
    assign condBranch  = resolveValid_i && !resolveIsJump_i;

    assign mispredict_o = resolveValid_i && (resolvePredTaken_i != actualTaken);
    assign redirectPc_o = actualTaken ? resolveTarget_i : resolvePc_i + PcStep;

    // BTB only learns taken control flow
    assign update.btbWrite  = resolveValid_i && actualTaken;
    assign update.btbPc     = resolvePc_i;
    assign update.btbTarget = resolveTarget_i;
    assign update.btbIsJump = resolveIsJump_i;

    // Counters train on conditional branches at the fetch-time history
    assign update.phtWrite = condBranch;
    assign update.phtIndex = resolveHistory_i;
    assign update.phtTaken = resolveTaken_i;

    // History restarts after any mispredict
    assign update.ghrClear = mispredict_o;
    assign update.ghrShift = condBranch && !mispredict_o;
    assign update.ghrTaken = resolveTaken_i;

endmodule

`default_nettype wire

// File: design/branchFrontEnd.sv
/*
 * Fetch-side branch prediction front end. The surrounding pipeline must
 * carry predTaken_o and predHistory_o to resolve alongside each branch.
 */
`default_nettype none

module branchFrontEnd #(
    parameter int             BtbEntries  = 16,
    parameter int             HistoryBits = 5,
    parameter branchPkg::pc_t ResetPc     = '0
) (
    input  wire logic                   clk,
    input  wire logic                   reset,

    // Fetch side
    input  wire logic                   stall_i,
    output branchPkg::pc_t              pc_o,
    output logic                        predTaken_o,
    output logic [HistoryBits-1:0]      predHistory_o,

    // Resolve side
    input  wire logic                   resolveValid_i,
    input  wire branchPkg::pc_t         resolvePc_i,
    input  wire branchPkg::pc_t         resolveTarget_i,
    input  wire logic                   resolveIsJump_i,
    input  wire logic                   resolveTaken_i,
    input  wire logic                   resolvePredTaken_i,
    input  wire logic [HistoryBits-1:0] resolveHistory_i,
    output logic                        mispredict_o
);
    import branchPkg::*;

    pc_t  redirectPc;
    pc_t  btbTarget;
    logic btbHit;
    logic btbIsJump;
    logic counterTaken;

    predictorUpdateIf #(.HistoryBits(HistoryBits)) updateBus ();

    // Jumps predict taken on any BTB hit, branches also need the counter
    assign predTaken_o = btbHit && (btbIsJump || counterTaken);

    fetchPc #(
        .ResetPc(ResetPc)
    ) uFetchPc (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall_i),
        .redirect_i   (mispredict_o),
        .redirectPc_i (redirectPc),
        .predTaken_i  (predTaken_o),
        .predTarget_i (btbTarget),
        .pc_o         (pc_o)
    );

    targetBuffer #(
        .BtbEntries(BtbEntries)
    ) uTargetBuffer (
        .clk        (clk),
        .reset      (reset),
        .lookupPc_i (pc_o),
        .update     (updateBus.btb),
        .hit_o      (btbHit),
        .isJump_o   (btbIsJump),
        .target_o   (btbTarget)
    );

    historyPredictor #(
        .HistoryBits(HistoryBits)
    ) uHistoryPredictor (
        .clk            (clk),
        .reset          (reset),
        .update         (updateBus.pht),
        .predictTaken_o (counterTaken),
        .history_o      (predHistory_o)
    );

    branchResolve #(
        .HistoryBits(HistoryBits)
    ) uBranchResolve (
        .resolveValid_i     (resolveValid_i),
        .resolvePc_i        (resolvePc_i),
        .resolveTarget_i    (resolveTarget_i),
        .resolveIsJump_i    (resolveIsJump_i),
        .resolveTaken_i     (resolveTaken_i),
        .resolvePredTaken_i (resolvePredTaken_i),
        .resolveHistory_i   (resolveHistory_i),
        .mispredict_o       (mispredict_o),
        .redirectPc_o       (redirectPc),
        .update             (updateBus.resolver)
    );

endmodule

`default_nettype wire

// File: test/branchFrontEnd_assert.sv
/*
 * Concurrent checks on fetch PC behavior that are bound into branchFrontEnd.
 * They only fire when the simulator runs with assertions enabled.
 */
`default_nettype none

module branchFrontEndAssert (
    input wire logic           clk,
    input wire logic           reset,
    input wire logic           stall_i,
    input wire logic           mispredict_i,
    input wire branchPkg::pc_t redirectPc_i,
    input wire branchPkg::pc_t pc_i,
    input wire logic           predTaken_i
);

    // A mispredict steers fetch on the very next edge even when stalled
    redirectLands: assert property (@(posedge clk) disable iff (reset)
        mispredict_i |=> (pc_i == $past(redirectPc_i)))
        else $error("redirect address did not reach pc_o on the next edge");

    stallHolds: assert property (@(posedge clk) disable iff (reset)
        (stall_i && !mispredict_i) |=> (pc_i == $past(pc_i)))
        else $error("pc_o moved while fetch was stalled");

    // Reset empties the BTB, so nothing can predict taken
    resetClearsPrediction: assert property (@(posedge clk)
        reset |=> !predTaken_i)
        else $error("predTaken_o was high in the cycle after reset");

endmodule

bind branchFrontEnd branchFrontEndAssert uAssert (
    .clk          (clk),
    .reset        (reset),
    .stall_i      (stall_i),
    .mispredict_i (mispredict_o),
    .redirectPc_i (redirectPc),
    .pc_i         (pc_o),
    .predTaken_i  (predTaken_o)
);

`default_nettype wire

// File: test/branchFrontEnd_tb.sv
/*
 * Testbench that checks the DUT at default parameters against a model of the BTB,
 * counters and GHR. Inputs change on the falling edge and outputs are checked 1 time unit later.
 */
`default_nettype none

module branchFrontEnd_tb;
    import branchPkg::*;

    localparam int  BtbEntries   = 16;
    localparam int  HistoryBits  = 5;
    localparam pc_t ResetPc      = '0;
    localparam int  RandomCycles = 120;
    // Tests take about 165 cycles
    localparam int  CycleLimit   = 400;

    logic clk, reset, stall, resolveValid, resolveIsJump, resolveTaken, resolvePredTaken;
    logic predTaken, mispredict;
    pc_t  resolvePc, resolveTarget, pc;
    logic [HistoryBits-1:0] resolveHistory, predHistory;

    // Reference model keeps the full PC in place of the tag
    logic                   btbValid  [BtbEntries];
    pc_t                    btbPc     [BtbEntries];
    logic                   btbJump   [BtbEntries];
    pc_t                    btbTarget [BtbEntries];
    logic [1:0]             pht       [1 << HistoryBits];
    logic [HistoryBits-1:0] modelGhr;
    pc_t                    modelPc;

    logic [31:0] rng;
    int errorCount, testCount, failedTests, cycleCount, errorsAtStart;

    branchFrontEnd UUT (
        .clk(clk), .reset(reset), .stall_i(stall), .pc_o(pc),
        .predTaken_o(predTaken), .predHistory_o(predHistory),
        .resolveValid_i(resolveValid), .resolvePc_i(resolvePc),
        .resolveTarget_i(resolveTarget), .resolveIsJump_i(resolveIsJump),
        .resolveTaken_i(resolveTaken), .resolvePredTaken_i(resolvePredTaken),
        .resolveHistory_i(resolveHistory), .mispredict_o(mispredict)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout, run stopped after %0d cycles", cycleCount);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int btbSlot(input pc_t addr);
        return int'(addr[31:2]) % BtbEntries;
    endfunction

    function automatic logic modelPredict(input pc_t fetchAddr);
        int slot;
        slot = btbSlot(fetchAddr);
        if (!btbValid[slot] || btbPc[slot] != fetchAddr) begin
            return 1'b0;
        end
        return btbJump[slot] || (pht[modelGhr] >= 2'd2);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("Fail %s: expected 0x%h, got 0x%h", name, expected, actual);
            errorCount++;
        end
    endtask

    // Drives one fetch cycle, checks the outputs and advances the model to the next edge
    task automatic runCycle(input logic stallIn, input logic validIn, input pc_t pcIn,
                            input pc_t targetIn, input logic jumpIn, input logic takenIn,
                            input logic predIn, input logic [HistoryBits-1:0] histIn);
        logic expTaken;
        logic expMiss;
        logic actual;
        int   slot;
        @(negedge clk);
        reset = 1'b0;
        stall = stallIn;
        resolveValid = validIn;
        resolvePc = pcIn;
        resolveTarget = targetIn;
        resolveIsJump = jumpIn;
        resolveTaken = takenIn;
        resolvePredTaken = predIn;
        resolveHistory = histIn;
        #1;
        actual   = jumpIn || takenIn;
        expTaken = modelPredict(modelPc);
        expMiss  = validIn && (jumpIn ? !predIn : (predIn != takenIn));
        checkValue("pc_o", pc, modelPc);
        checkValue("predTaken_o", 32'(predTaken), 32'(expTaken));
        checkValue("predHistory_o", 32'(predHistory), 32'(modelGhr));
        checkValue("mispredict_o", 32'(mispredict), 32'(expMiss));
        if (expMiss) begin
            modelPc = actual ? targetIn : pcIn + PcStep;
        end else if (!stallIn) begin
            modelPc = expTaken ? btbTarget[btbSlot(modelPc)] : modelPc + PcStep;
        end
        if (validIn && actual) begin
            slot = btbSlot(pcIn);
            btbValid[slot]  = 1'b1;
            btbPc[slot]     = pcIn;
            btbJump[slot]   = jumpIn;
            btbTarget[slot] = targetIn;
        end
        if (validIn && !jumpIn) begin
            if (takenIn && pht[histIn] != 2'd3) begin
                pht[histIn] = pht[histIn] + 2'd1;
            end else if (!takenIn && pht[histIn] != 2'd0) begin
                pht[histIn] = pht[histIn] - 2'd1;
            end
        end
        if (expMiss) begin
            modelGhr = '0;
        end else if (validIn && !jumpIn) begin
            modelGhr = {modelGhr[HistoryBits-2:0], takenIn};
        end
    endtask

    task automatic idleCycle(input logic stallIn);
        runCycle(stallIn, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, '0);
    endtask

    task automatic reportTest(input string name);
        testCount++;
        if (errorCount == errorsAtStart) begin
            $display("Test %0d, %s: ok", testCount, name);
        end else begin
            failedTests++;
            $display("Test %0d, %s: %0d errors", testCount, name, errorCount - errorsAtStart);
        end
        errorsAtStart = errorCount;
    endtask

    initial begin
        pc_t  branchPc;
        pc_t  target;
        logic isJump;
        clk = 1'b0;
        reset = 1'b1;
        stall = 1'b0;
        resolveValid = 1'b0;
        resolvePc = '0;
        resolveTarget = '0;
        resolveIsJump = 1'b0;
        resolveTaken = 1'b0;
        resolvePredTaken = 1'b0;
        resolveHistory = '0;
        rng = 32'he68a_dabe;
        modelPc = ResetPc;
        modelGhr = '0;
        for (int i = 0; i < BtbEntries; i++) begin
            btbValid[i] = 1'b0;
        end
        for (int i = 0; i < (1 << HistoryBits); i++) begin
            pht[i] = 2'd1;
        end
        repeat (2) @(posedge clk);

        repeat (6) idleCycle(1'b0);
        reportTest("reset and sequential fetch");

        repeat (3) idleCycle(1'b1);
        runCycle(1'b1, 1'b1, 32'h10, 32'h1000, 1'b0, 1'b1, 1'b0, modelGhr);
        idleCycle(1'b1);
        checkValue("pc_o", pc, 32'h1000);
        reportTest("stall and redirect during stall");

        // A correctly predicted taken branch leaves the GHR nonzero before the jump
        runCycle(1'b0, 1'b1, 32'h20, 32'h200, 1'b0, 1'b1, 1'b1, modelGhr);
        runCycle(1'b0, 1'b1, 32'h40, 32'h100, 1'b1, 1'b1, 1'b0, modelGhr);
        checkValue("mispredict_o", 32'(mispredict), 32'd1);
        idleCycle(1'b0);
        checkValue("pc_o", pc, 32'h100);
        checkValue("predHistory_o", 32'(predHistory), 32'd0);
        reportTest("jump mispredict");

        runCycle(1'b0, 1'b1, 32'h30, 32'h300, 1'b0, 1'b0, 1'b1, modelGhr);
        idleCycle(1'b0);
        checkValue("pc_o", pc, 32'h34);
        reportTest("taken prediction resolved not taken");

        repeat (3) idleCycle(1'b0);
        checkValue("predTaken_o", 32'(predTaken), 32'd1);
        idleCycle(1'b0);
        checkValue("pc_o", pc, 32'h100);
        reportTest("BTB jump prediction");

        // Park fetch on a trained branch, then drive its counters to both ends
        runCycle(1'b0, 1'b1, 32'h60, 32'h80, 1'b0, 1'b1, 1'b1, modelGhr);
        runCycle(1'b0, 1'b1, 32'h50, 32'h60, 1'b1, 1'b1, 1'b0, modelGhr);
        repeat (8) runCycle(1'b1, 1'b1, 32'h70, 32'h90, 1'b0, 1'b1, 1'b1, modelGhr);
        repeat (9) runCycle(1'b1, 1'b1, 32'h70, 32'h90, 1'b0, 1'b0, 1'b0, modelGhr);
        for (int i = 0; i < RandomCycles; i++) begin
            rng = xorshift(rng);
            branchPc = 32'h40 + (rng & 32'h1c);
            target   = 32'h40 + ((rng >> 3) & 32'h1c);
            isJump   = (rng[8:6] == 3'd0);
            runCycle(rng[12:11] == 2'd0, rng[13], branchPc, target, isJump,
                     rng[9] || isJump, modelPredict(branchPc), modelGhr);
        end
        reportTest("random branches and saturation");

        $display("Tests: %0d run, %0d failed, %0d check errors",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
design/branchPkg.sv
design/predictorUpdateIf.sv
design/fetchPc.sv
design/targetBuffer.sv
design/historyPredictor.sv
design/branchResolve.sv
design/branchFrontEnd.sv
test/branchFrontEnd_assert.sv
test/branchFrontEnd_tb.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, success only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module branchFrontEnd_tb -f files.f \
    && ./obj_dir/VbranchFrontEnd_tb | tee /dev/stderr | grep -qx "PASS: all tests" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
